// File: board_mover.sv
// Player positions, exact-finish hold, snake/ladder jump and lights
`timescale 1ns/1ps
`default_nettype none

module board_mover
	import snl_game_pkg::*;
(
	input  wire       KEY,
	input  wire       arst_n,
	input  wire       step,	// Register tentative square
	input  wire       settle,	// Write jump target back
	input  wire       clear,	// New game
	input  player_t   mover,	// Player being moved
	input  face_t     face,	// Captured roll value
	output position_t pos_p1,
	output position_t pos_p2,
	output logic      ladder,	// Last move climbed
	output logic      snake,	// Last move slid down
	output logic      at_end	// Settle lands on the finish
);

	position_t cur_pos;	// Mover's square before the roll
	position_t sum_pos;	// Square plus face, may pass 100
	position_t land;	// Tentative square after the step
	position_t dest;	// Square after snake or ladder

	always_comb
	begin
		cur_pos = (mover == PLAYER_2) ? pos_p2 : pos_p1;
		sum_pos = cur_pos + position_t'(face);	// At most 107, fits 7 bits
		dest    = jump_target(land);
		at_end  = settle && (dest == BOARD_END);
	end

	// Overshoot leaves the player where they stand
	always_ff @(posedge KEY)
	begin
		if (step)
			land <= (sum_pos > BOARD_END) ? cur_pos : sum_pos;
	end

	always_ff @(posedge KEY or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pos_p1 <= '0;
			pos_p2 <= '0;
			ladder <= 1'b0;
			snake  <= 1'b0;
		end
		else if (clear)
		begin
			pos_p1 <= '0;	// Both back to start
			pos_p2 <= '0;
			ladder <= 1'b0;
			snake  <= 1'b0;
		end
		else if (settle)
		begin
			if (mover == PLAYER_2)
				pos_p2 <= dest;
			else
				pos_p1 <= dest;
			ladder <= (dest > land);	// Rose past the landing square
			snake  <= (dest < land);	// Dropped below it
		end
	end

endmodule

`default_nettype wire

// File: dice_counter.sv
// Free-running dice face counter with captured roll value
`timescale 1ns/1ps
`default_nettype none

module dice_counter
	import snl_game_pkg::*;
#(
	parameter int unsigned DICE_FACES = 6	// Top face, at most 7
)
(
	input  wire   KEY,
	input  wire   arst_n,
	input  wire   capture,	// Roll accepted this cycle
	input  wire   clear,	// New game
	output face_t face	// Captured roll, 0 until first roll
);

	face_t count;	// Runs 1..DICE_FACES, sampled by a roll

	// Counter never stops, the moment of the roll picks the face
	always_ff @(posedge KEY or negedge arst_n)
	begin
		if (!arst_n)
		begin
			count <= '0;	// First edge brings it to 1
		end
		else if (count >= face_t'(DICE_FACES))
		begin
			count <= face_t'(1);	// Wrap after top face
		end
		else
		begin
			count <= count + face_t'(1);
		end
	end

	// Held roll value for mover, FSM and display
	always_ff @(posedge KEY or negedge arst_n)
	begin
		if (!arst_n)
			face <= '0;
		else if (clear)
			face <= '0;	// Blank dice on new game
		else if (capture)
			face <= count;
	end

endmodule

`default_nettype wire

// File: files.f
snl_game_pkg.sv
snl_display_pkg.sv
dice_counter.sv
turn_fsm.sv
board_mover.sv
score_display.sv
snl_top.sv
tb_snl_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the game testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f files.f \
	--top-module tb_snl_top -o tb_snl_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_snl_top
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit $status
fi
echo "Simulation finished with status 0"
exit 0

// File: score_display.sv
// Decimal split of positions and seven-segment encoding of all readouts
`timescale 1ns/1ps
`default_nettype none

module score_display
	import snl_game_pkg::*;
	import snl_display_pkg::*;
(
	input  position_t pos_p1,
	input  position_t pos_p2,
	input  face_t     face,
	input  player_t   turn,
	input  player_t   winner,
	output seg_t      seg_p1_tens,
	output seg_t      seg_p1_ones,
	output seg_t      seg_p2_tens,
	output seg_t      seg_p2_ones,
	output seg_t      seg_dice,
	output seg_t      seg_turn,
	output seg_t      seg_winner
);

	digit_t p1_tens, p1_ones;
	digit_t p2_tens, p2_ones;

	// Tens by repeated subtraction, 100 gives tens 10
	function automatic void split_dec(input position_t value, output digit_t tens,
		output digit_t ones);
		position_t rest;
		rest = value;
		tens = '0;
		for (int i = 0; i < 10; i++)
		begin
			if (rest >= 7'd10)
			begin
				rest = rest - 7'd10;
				tens = tens + 4'd1;
			end
		end
		ones = digit_t'(rest);	// Remainder below ten
	endfunction

	always_comb
	begin
		split_dec(pos_p1, p1_tens, p1_ones);
		split_dec(pos_p2, p2_tens, p2_ones);
		seg_p1_tens = seg_encode(p1_tens);	// Shows "A" at the finish
		seg_p1_ones = seg_encode(p1_ones);
		seg_p2_tens = seg_encode(p2_tens);
		seg_p2_ones = seg_encode(p2_ones);
		seg_dice    = seg_encode({1'b0, face});
		seg_turn    = seg_encode({2'b00, turn});
		seg_winner  = seg_encode({2'b00, winner});	// 0 while nobody won
	end

endmodule

`default_nettype wire

// File: snl_cases.txt
# op gap face pos_p1 pos_p2 turn winner ladder snake
# gap is idle cycles before op, the other columns are expected 3 cycles after op
roll 4 4 14 0 2 0 1 0
roll 2 3 14 3 1 0 0 0
roll 0 6 20 3 1 0 0 0
roll 4 1 42 3 2 0 1 0
roll 1 5 42 30 1 0 1 0
roll 4 6 26 30 1 0 0 1
roll 5 2 76 30 2 0 1 0
roll 3 2 76 10 1 0 0 1
roll 5 4 99 10 2 0 1 0
roll 4 5 99 15 1 0 0 0
roll 1 3 99 15 2 0 0 0
roll 0 6 99 42 2 0 1 0
roll 4 1 99 43 1 0 0 0
roll 3 1 100 43 1 1 0 0
roll 2 1 100 43 1 1 0 0
new 1 0 0 0 1 0 0 0
roll 4 5 5 0 2 0 0 0
roll 2 4 5 14 1 0 1 0
roll 2 3 30 14 2 0 1 0
roll 0 6 30 20 2 0 0 0
roll 0 3 30 23 1 0 0 0

// File: snl_display_pkg.sv
// Decimal digit and segment types, hex glyph encoder
`default_nettype none

package snl_display_pkg;

	typedef logic [3:0] digit_t;	// One displayed digit, hex range
	typedef logic [6:0] seg_t;	// Active low, bit 0 is segment a, bit 6 is g

	// Standard hex glyphs, so ten shows as "A"
	function automatic seg_t seg_encode(input digit_t value);
		case (value)
			4'h0:    return 7'b1000000;
			4'h1:    return 7'b1111001;
			4'h2:    return 7'b0100100;
			4'h3:    return 7'b0110000;
			4'h4:    return 7'b0011001;
			4'h5:    return 7'b0010010;
			4'h6:    return 7'b0000010;
			4'h7:    return 7'b1111000;
			4'h8:    return 7'b0000000;
			4'h9:    return 7'b0010000;
			4'hA:    return 7'b0001000;
			4'hB:    return 7'b0000011;	// Lower case b
			4'hC:    return 7'b1000110;
			4'hD:    return 7'b0100001;	// Lower case d
			4'hE:    return 7'b0000110;
			default: return 7'b0001110;	// F
		endcase
	endfunction

endpackage

`default_nettype wire

// File: snl_game_pkg.sv
// Game types, player codes, board limit and snake/ladder jump table
`default_nettype none

package snl_game_pkg;

	typedef logic [6:0] position_t;	// Board square 0..100
	typedef logic [1:0] player_t;	// 0 none, 1 P1, 2 P2
	typedef logic [2:0] face_t;	// Dice face, 0 while nothing rolled

	localparam player_t PLAYER_NONE = 2'd0;
	localparam player_t PLAYER_1    = 2'd1;
	localparam player_t PLAYER_2    = 2'd2;

	localparam position_t BOARD_END = 7'd100;	// Exact finish square

	// Destination of a landing square, itself when no snake or ladder
	function automatic position_t jump_target(input position_t square);
		case (square)
			7'd4:    return 7'd14;	// Ladders
			7'd8:    return 7'd30;
			7'd21:   return 7'd42;
			7'd28:   return 7'd76;
			7'd50:   return 7'd67;
			7'd71:   return 7'd92;
			7'd80:   return 7'd99;
			7'd32:   return 7'd10;	// Snakes
			7'd36:   return 7'd6;
			7'd48:   return 7'd26;
			7'd62:   return 7'd18;
			7'd88:   return 7'd24;
			7'd95:   return 7'd56;
			7'd97:   return 7'd78;
			default: return square;	// Plain square
		endcase
	endfunction

endpackage

`default_nettype wire

// File: snl_top.sv
// Game top level with dice counter, turn FSM, board mover and display
`timescale 1ns/1ps
`default_nettype none

module snl_top
	import snl_game_pkg::*;
	import snl_display_pkg::*;
#(
	parameter int unsigned DICE_FACES = 6	// Faces on the die, up to 7
)
(
	input  wire       KEY,	// System clock
	input  wire       arst_n,
	input  wire       game_on,	// Low starts a new game
	input  wire       roll,	// One-cycle roll pulse
	output seg_t      seg_p1_tens,
	output seg_t      seg_p1_ones,
	output seg_t      seg_p2_tens,
	output seg_t      seg_p2_ones,
	output seg_t      seg_dice,
	output seg_t      seg_turn,
	output seg_t      seg_winner,
	output position_t pos_p1,
	output position_t pos_p2,
	output player_t   turn,
	output player_t   winner,
	output face_t     face,
	output logic      ladder,	// Ladder light
	output logic      snake	// Snake light
);

	logic    capture;
	logic    step;
	logic    settle;
	logic    clear;
	logic    at_end;
	player_t mover;

	dice_counter #(.DICE_FACES(DICE_FACES)) i_dice_counter
	(
		.KEY     (KEY),
		.arst_n  (arst_n),
		.capture (capture),
		.clear   (clear),
		.face    (face)
	);

	turn_fsm #(.DICE_FACES(DICE_FACES)) i_turn_fsm
	(
		.KEY     (KEY),
		.arst_n  (arst_n),
		.game_on (game_on),
		.roll    (roll),
		.face    (face),
		.at_end  (at_end),
		.capture (capture),
		.step    (step),
		.settle  (settle),
		.clear   (clear),
		.mover   (mover),
		.turn    (turn),
		.winner  (winner)
	);

	board_mover i_board_mover
	(
		.KEY    (KEY),
		.arst_n (arst_n),
		.step   (step),
		.settle (settle),
		.clear  (clear),
		.mover  (mover),
		.face   (face),
		.pos_p1 (pos_p1),
		.pos_p2 (pos_p2),
		.ladder (ladder),
		.snake  (snake),
		.at_end (at_end)
	);

	// Pure decode of the visible game state
	score_display i_score_display
	(
		.pos_p1      (pos_p1),
		.pos_p2      (pos_p2),
		.face        (face),
		.turn        (turn),
		.winner      (winner),
		.seg_p1_tens (seg_p1_tens),
		.seg_p1_ones (seg_p1_ones),
		.seg_p2_tens (seg_p2_tens),
		.seg_p2_ones (seg_p2_ones),
		.seg_dice    (seg_dice),
		.seg_turn    (seg_turn),
		.seg_winner  (seg_winner)
	);

endmodule

`default_nettype wire

// File: tb_snl_top.sv
// Testbench for the game top level with clock, reset, case reader, compare tasks and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_snl_top
	import snl_game_pkg::*;
	import snl_display_pkg::*;
();

	localparam logic [31:0] OP_ROLL = "roll";
	localparam logic [31:0] OP_NEW  = {8'h00, "new"};	// Short word lands right-aligned

	logic      KEY;
	logic      arst_n;
	logic      game_on;
	logic      roll;
	seg_t      seg_p1_tens;
	seg_t      seg_p1_ones;
	seg_t      seg_p2_tens;
	seg_t      seg_p2_ones;
	seg_t      seg_dice;
	seg_t      seg_turn;
	seg_t      seg_winner;
	position_t pos_p1;
	position_t pos_p2;
	player_t   turn;
	player_t   winner;
	face_t     face;
	logic      ladder;
	logic      snake;

	// Stimulus and expected state, one entry per case
	logic [31:0] op_q[$];
	int          gap_q[$];
	face_t       face_q[$];
	position_t   p1_q[$];
	position_t   p2_q[$];
	player_t     turn_q[$];
	player_t     winner_q[$];
	logic        ladder_q[$];
	logic        snake_q[$];
	int          max_gap;	// Longest idle gap, sizes the watchdog
	int          case_no;	// 0 is the reset check
	bit          cases_ready;

	snl_top #(.DICE_FACES(6)) i_snl_top (.*);	// Cases assume a six-faced die

	initial
	begin
		KEY = 1'b0;
		forever #5 KEY = ~KEY;	// 10 ns period
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_pos(input position_t actual, input position_t expected,
		input string what);
		if (actual !== expected)
			stop_run($sformatf("ERROR at %0d ns: case %0d, %s is %0d, expected %0d",
				$time, case_no, what, actual, expected));
	endtask

	task automatic check_player(input player_t actual, input player_t expected,
		input string what);
		if (actual !== expected)
			stop_run($sformatf("ERROR at %0d ns: case %0d, %s is %0d, expected %0d",
				$time, case_no, what, actual, expected));
	endtask

	task automatic check_face(input face_t actual, input face_t expected, input string what);
		if (actual !== expected)
			stop_run($sformatf("ERROR at %0d ns: case %0d, %s is %0d, expected %0d",
				$time, case_no, what, actual, expected));
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string what);
		if (actual !== expected)
			stop_run($sformatf("ERROR at %0d ns: case %0d, %s is %b, expected %b",
				$time, case_no, what, actual, expected));
	endtask

	task automatic check_seg(input seg_t actual, input seg_t expected, input string what);
		if (actual !== expected)
			stop_run($sformatf("ERROR at %0d ns: case %0d, %s is %b, expected %b",
				$time, case_no, what, actual, expected));
	endtask

	// Every output port against one expected game state
	task automatic compare_outputs(input face_t e_face, input position_t e_p1,
		input position_t e_p2, input player_t e_turn, input player_t e_winner,
		input logic e_ladder, input logic e_snake);
		check_face(face, e_face, "face");
		check_pos(pos_p1, e_p1, "pos_p1");
		check_pos(pos_p2, e_p2, "pos_p2");
		check_player(turn, e_turn, "turn");
		check_player(winner, e_winner, "winner");
		check_flag(ladder, e_ladder, "ladder");
		check_flag(snake, e_snake, "snake");
		// Decimal digits, square 100 reads as tens 10
		check_seg(seg_p1_tens, seg_encode(digit_t'(e_p1 / 7'd10)), "seg_p1_tens");
		check_seg(seg_p1_ones, seg_encode(digit_t'(e_p1 % 7'd10)), "seg_p1_ones");
		check_seg(seg_p2_tens, seg_encode(digit_t'(e_p2 / 7'd10)), "seg_p2_tens");
		check_seg(seg_p2_ones, seg_encode(digit_t'(e_p2 % 7'd10)), "seg_p2_ones");
		check_seg(seg_dice, seg_encode(digit_t'(e_face)), "seg_dice");
		check_seg(seg_turn, seg_encode(digit_t'(e_turn)), "seg_turn");
		check_seg(seg_winner, seg_encode(digit_t'(e_winner)), "seg_winner");
	endtask

	task automatic read_cases();
		int          fd;
		int          code;
		int          fields;
		string       line;
		logic [31:0] op;
		int          col[8];	// Gap, face, p1, p2, turn, winner, ladder, snake
		fd = $fopen("snl_cases.txt", "r");
		if (fd == 0)
			stop_run("Cannot open snl_cases.txt, the run must start in the project root");
		max_gap = 0;
		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			if (code > 0 && line.len() > 1 && line[0] != "#")	// Skip blanks and comments
			begin
				fields = $sscanf(line, "%s %d %d %d %d %d %d %d %d", op, col[0], col[1],
					col[2], col[3], col[4], col[5], col[6], col[7]);
				if (fields != 9 || (op != OP_ROLL && op != OP_NEW))
					stop_run({"Bad line in snl_cases.txt: ", line});
				op_q.push_back(op);
				gap_q.push_back(col[0]);
				face_q.push_back(face_t'(col[1]));
				p1_q.push_back(position_t'(col[2]));
				p2_q.push_back(position_t'(col[3]));
				turn_q.push_back(player_t'(col[4]));
				winner_q.push_back(player_t'(col[5]));
				ladder_q.push_back(col[6] != 0);
				snake_q.push_back(col[7] != 0);
				if (col[0] > max_gap)
					max_gap = col[0];
			end
		end
		$fclose(fd);
		if (op_q.size() == 0)
			stop_run("snl_cases.txt holds no cases");
	endtask

	task automatic next_cycle();
		@(posedge KEY);
		#1;	// Drive and sample clear of the edge
	endtask

	initial
	begin
		arst_n  = 1'b0;
		game_on = 1'b1;
		roll    = 1'b0;
		case_no = 0;
		read_cases();
		cases_ready = 1'b1;
		repeat (8) @(posedge KEY);	// Reset held 8 cycles
		#1;
		arst_n = 1'b1;
		compare_outputs('0, '0, '0, PLAYER_1, PLAYER_NONE, 1'b0, 1'b0);
		for (int i = 0; i < op_q.size(); i++)
		begin
			case_no = i + 1;
			repeat (gap_q[i]) next_cycle();	// Free counter advances, picks the face
			if (op_q[i] == OP_ROLL)
				roll = 1'b1;
			else
				game_on = 1'b0;	// New game for one cycle
			next_cycle();
			roll    = 1'b0;
			game_on = 1'b1;
			repeat (2) next_cycle();	// Step, then settle
			compare_outputs(face_q[i], p1_q[i], p2_q[i], turn_q[i], winner_q[i],
				ladder_q[i], snake_q[i]);
		end
		$display("sim passed");
		$finish;
	end

	// Watchdog, longest case times case count plus reset and margin
	initial
	begin
		wait (cases_ready);
		#((op_q.size() * (max_gap + 3) + 8 + 20) * 10);
		stop_run("Timeout, the cases did not finish in the expected time");
	end

endmodule

`default_nettype wire

// File: turn_fsm.sv
// Roll sequencing FSM with turn order, extra turn on top face and winner lock
`timescale 1ns/1ps
`default_nettype none

module turn_fsm
	import snl_game_pkg::*;
#(
	parameter int unsigned DICE_FACES = 6	// Face that earns another roll
)
(
	input  wire     KEY,
	input  wire     arst_n,
	input  wire     game_on,	// Low holds the new-game state
	input  wire     roll,	// One-cycle roll request
	input  face_t   face,	// Captured roll value
	input  wire     at_end,	// Settled square is the finish
	output logic    capture,	// Sample dice counter
	output logic    step,	// Add face to mover's square
	output logic    settle,	// Apply jump, update lights
	output logic    clear,	// New game for dice and board
	output player_t mover,	// Player being moved
	output player_t turn,	// Player allowed to roll
	output player_t winner	// None until someone lands on 100
);

	typedef enum logic [1:0]
	{
		ST_IDLE,	// Waiting for a roll
		ST_STEP,	// Tentative square being registered
		ST_SETTLE,	// Jump applied, turn decided
		ST_WON	// Game over, rolls ignored
	} state_t;

	state_t  state;
	player_t other;	// Player who rolls next on a normal turn

	always_comb
	begin
		clear   = !game_on;
		capture = game_on && roll && (state == ST_IDLE);	// Busy or won drops the roll
		step    = (state == ST_STEP);
		settle  = (state == ST_SETTLE);
		mover   = turn;	// Turn only changes after settle
		other   = (turn == PLAYER_1) ? PLAYER_2 : PLAYER_1;
	end

	always_ff @(posedge KEY or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state  <= ST_IDLE;
			turn   <= PLAYER_1;	// P1 always opens
			winner <= PLAYER_NONE;
		end
		else if (!game_on)
		begin
			state  <= ST_IDLE;	// Abort any move in flight
			turn   <= PLAYER_1;
			winner <= PLAYER_NONE;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					if (roll)
						state <= ST_STEP;
				end
				ST_STEP:
				begin
					state <= ST_SETTLE;
				end
				ST_SETTLE:
				begin
					if (at_end)
					begin
						winner <= mover;	// Turn frozen on the winner
						state  <= ST_WON;
					end
					else
					begin
						if (face != face_t'(DICE_FACES))
							turn <= other;	// Top face keeps the same player
						state <= ST_IDLE;
					end
				end
				default:
				begin
					state <= ST_WON;	// Locked until game_on drops
				end
			endcase
		end
	end

endmodule

`default_nettype wire
